// File: flist.f
verilog/icache_pkg.sv
verilog/icache_array_if.sv
verilog/icache_ways.sv
verilog/icache_plru.sv
verilog/icache_ctrl.sv
verilog/icache_top.sv
test/icache_mem_model.sv
test/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j $(JOBS)
PASS_TEXT ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search the output for the pass message"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FLIST OBJ_DIR JOBS VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// File: test/icache_tb.sv
`timescale 1ns/1ps

module icache_tb;

    localparam int          clk_half       = 10;
    localparam int          reset_cycles   = 8;
    localparam logic [31:0] rand_seed      = 32'h139f;
    localparam logic [31:0] data_mask      = 32'h5a5a_0000;
    localparam int          num_entries    = 21;
    localparam int          timeout_cycles = reset_cycles + num_entries * 40;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] reads;
    } stim_t;

    // Address and expected demand reads before the response
    localparam stim_t stim [num_entries] = '{
        '{32'h0000_2004, 32'd1},  // Cold miss, neighbour 0x2020 prefetched
        '{32'h0000_2008, 32'd0},
        '{32'h0000_201c, 32'd0},
        '{32'h0000_2024, 32'd0},  // Prefetched line
        '{32'h0000_2030, 32'd0},
        '{32'h0000_2040, 32'd1},
        '{32'h0000_2064, 32'd0},
        '{32'h0000_31e8, 32'd1},  // Set 15, neighbour wraps to set 0
        '{32'h0000_3200, 32'd0},
        '{32'h0000_4080, 32'd1},  // Set 4 way 0
        '{32'h0000_4284, 32'd1},  // Set 4 way 1
        '{32'h0000_4488, 32'd1},  // Set 4 way 2
        '{32'h0000_468c, 32'd1},  // Set 4 way 3
        '{32'h0000_4090, 32'd0},  // Touch way 0, tree now points at way 2
        '{32'h0000_4894, 32'd1},  // Evicts 0x4480
        '{32'h0000_4098, 32'd0},
        '{32'h0000_429c, 32'd0},
        '{32'h0000_4680, 32'd0},
        '{32'h0000_4884, 32'd0},
        '{32'h0000_4488, 32'd1},  // Evicted line comes back
        '{32'h0000_48a4, 32'd0}
    };

    logic                          clk;
    logic                          arst_n;
    logic                          cpu_read;
    logic [31:0]                   cpu_addr;
    logic [icache_pkg::word_w-1:0] cpu_rdata;
    logic                          cpu_resp;
    logic                          mem_read;
    logic [31:0]                   mem_addr;
    logic [icache_pkg::line_w-1:0] mem_rdata;
    logic                          mem_resp;

    int errors = 0;
    int checks = 0;

    icache_top u_icache_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .cpu_read  (cpu_read),
        .cpu_addr  (cpu_addr),
        .cpu_rdata (cpu_rdata),
        .cpu_resp  (cpu_resp),
        .mem_read  (mem_read),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

    icache_mem_model #(
        .seed (rand_seed)
    ) u_mem_model (
        .clk       (clk),
        .arst_n    (arst_n),
        .mem_read  (mem_read),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #clk_half clk = ~clk;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic run_access(input stim_t entry);
        logic [31:0] line;
        int          cycles;
        int          reads;
        line   = {entry.addr[31:5], 5'b0};
        cycles = 0;
        reads  = 0;
        @(posedge clk);
        #1;
        cpu_read = 1'b1;
        cpu_addr = entry.addr;
        // Mid-cycle samples, demand fills counted up to the response
        do begin
            @(negedge clk);
            cycles++;
            if (mem_read && mem_resp) begin
                reads++;
                check_value("demand address", mem_addr, line);
            end
        end while (!cpu_resp);
        check_value("read word", cpu_rdata, (entry.addr & 32'hffff_fffc) ^ data_mask);
        check_value("demand reads", 32'(reads), entry.reads);
        if (entry.reads == 0) begin
            // Idle cycle, then response in compare
            check_value("hit latency", 32'(cycles), 32'd2);
        end
        @(posedge clk);
        #1;
        cpu_read = 1'b0;
        // Wait out a prefetch before the next request
        @(negedge clk);
        if (mem_read) begin
            check_value("prefetch address", mem_addr, line + 32'd32);
            while (!mem_resp) begin
                @(negedge clk);
            end
        end
    endtask

    initial begin
        arst_n   = 1'b0;
        cpu_read = 1'b0;
        cpu_addr = '0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        check_value("cpu_resp after reset", 32'(cpu_resp), 32'd0);
        check_value("mem_read after reset", 32'(mem_read), 32'd0);
        for (int i = 0; i < num_entries; i++) begin
            run_access(stim[i]);
        end
        $display("Closing report: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: the cache gave no response within %0d cycles", timeout_cycles);
        $display("Test failed");
        $finish;
    end

endmodule

// File: test/icache_mem_model.sv
`timescale 1ns/1ps

module icache_mem_model #(
    parameter logic [31:0] seed = 32'h1
) (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          mem_read,
    input  logic [31:0]                   mem_addr,
    output logic [icache_pkg::line_w-1:0] mem_rdata,
    output logic                          mem_resp
);

    // Every word holds its own byte address XOR a fixed mask
    function automatic logic [icache_pkg::line_w-1:0] line_data(input logic [31:0] line_addr);
        logic [icache_pkg::line_w-1:0] data;
        for (int i = 0; i < icache_pkg::line_w / 32; i++) begin
            data[i*32 +: 32] = (line_addr + 32'(i * 4)) ^ 32'h5a5a_0000;
        end
        return data;
    endfunction

    // One read at a time, answered 2 to 9 cycles after mem_read rises
    initial begin
        int          delay;
        logic [31:0] addr;
        void'($urandom(seed));
        mem_resp  = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (arst_n && mem_read) begin
                addr  = mem_addr;
                delay = 2 + int'($urandom % 8);
                repeat (delay) @(posedge clk);
                #1;
                mem_rdata = line_data(addr);
                mem_resp  = 1'b1;
                @(posedge clk);
                #1;
                mem_resp = 1'b0;
            end
        end
    end

endmodule

// File: verilog/icache_top.sv
`timescale 1ns/1ps

module icache_top (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          cpu_read,
    input  logic [31:0]                   cpu_addr,
    output logic [icache_pkg::word_w-1:0] cpu_rdata,
    output logic                          cpu_resp,
    output logic                          mem_read,
    output logic [31:0]                   mem_addr,
    input  logic [icache_pkg::line_w-1:0] mem_rdata,
    input  logic                          mem_resp
);

    icache_pkg::addr_u req_addr;

    logic [icache_pkg::index_w-1:0] plru_index;
    logic                           plru_touch;
    logic [icache_pkg::way_w-1:0]   plru_way;
    logic [icache_pkg::way_w-1:0]   victim_way;

    icache_array_if arr_if ();

    assign req_addr.raw = cpu_addr;

    icache_ctrl u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .cpu_read   (cpu_read),
        .cpu_addr   (req_addr),
        .cpu_rdata  (cpu_rdata),
        .cpu_resp   (cpu_resp),
        .mem_read   (mem_read),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .mem_resp   (mem_resp),
        .arr        (arr_if.ctrl),
        .plru_index (plru_index),
        .plru_touch (plru_touch),
        .plru_way   (plru_way),
        .victim_way (victim_way)
    );

    icache_ways u_ways (
        .clk    (clk),
        .arst_n (arst_n),
        .arr    (arr_if.store)
    );

    icache_plru u_plru (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (plru_index),
        .touch      (plru_touch),
        .touch_way  (plru_way),
        .victim_way (victim_way)
    );

endmodule

// File: verilog/icache_ctrl.sv
`timescale 1ns/1ps

module icache_ctrl (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           cpu_read,
    input  icache_pkg::addr_u              cpu_addr,
    output logic [icache_pkg::word_w-1:0]  cpu_rdata,
    output logic                           cpu_resp,
    output logic                           mem_read,
    output logic [31:0]                    mem_addr,
    input  logic [icache_pkg::line_w-1:0]  mem_rdata,
    input  logic                           mem_resp,
    icache_array_if.ctrl                   arr,
    output logic [icache_pkg::index_w-1:0] plru_index,
    output logic                           plru_touch,
    output logic [icache_pkg::way_w-1:0]   plru_way,
    input  logic [icache_pkg::way_w-1:0]   victim_way
);

    icache_pkg::ctrl_state_e state_q;
    icache_pkg::ctrl_state_e next_state;

    icache_pkg::addr_u req_q;
    icache_pkg::addr_u demand_line;
    icache_pkg::addr_u pf_line;
    icache_pkg::addr_u look_line;

    // Set after a demand fill, so the next hit response starts a prefetch
    logic fill_q;

    logic                         hit;
    logic [icache_pkg::way_w-1:0] hit_way;
    logic [icache_pkg::way_w-1:0] fill_way;

    assign demand_line.raw = {req_q.raw[31:icache_pkg::offset_w], {icache_pkg::offset_w{1'b0}}};
    assign pf_line.raw     = demand_line.raw + 32'(icache_pkg::line_w / 8);

    // Prefetch state looks at the neighbour line, everything else at the request
    assign look_line = (state_q == icache_pkg::prefetch_s) ? pf_line : demand_line;

    assign arr.index   = look_line.f.index;
    assign arr.wr_way  = fill_way;
    assign arr.wr_tag  = look_line.f.tag;
    assign arr.wr_line = mem_rdata;
    assign mem_addr    = look_line.raw;
    assign plru_index  = look_line.f.index;

    // Tag compare across all ways
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < icache_pkg::ways; w++) begin
            if (arr.rd_valid[w] && arr.rd_tag[w] == look_line.f.tag) begin
                hit     = 1'b1;
                hit_way = icache_pkg::way_w'(w);
            end
        end
    end

    // Lowest invalid way wins, otherwise the PLRU victim
    always_comb begin
        fill_way = victim_way;
        for (int w = icache_pkg::ways - 1; w >= 0; w--) begin
            if (!arr.rd_valid[w]) begin
                fill_way = icache_pkg::way_w'(w);
            end
        end
    end

    // Word select by offset bits 4:2
    assign cpu_rdata =
        arr.rd_line[hit_way][req_q.f.offset[icache_pkg::offset_w-1:2] * icache_pkg::word_w +:
                             icache_pkg::word_w];

    always_comb begin
        next_state = state_q;
        cpu_resp   = 1'b0;
        mem_read   = 1'b0;
        arr.wr_en  = 1'b0;
        plru_touch = 1'b0;
        plru_way   = hit_way;
        case (state_q)
            icache_pkg::idle_s: begin
                if (cpu_read) begin
                    next_state = icache_pkg::compare_s;
                end
            end
            icache_pkg::compare_s: begin
                if (hit) begin
                    cpu_resp   = 1'b1;
                    plru_touch = 1'b1;
                    next_state = fill_q ? icache_pkg::prefetch_s : icache_pkg::idle_s;
                end else begin
                    next_state = icache_pkg::allocate_s;
                end
            end
            icache_pkg::allocate_s: begin
                mem_read = 1'b1;
                if (mem_resp) begin
                    arr.wr_en  = 1'b1;
                    plru_touch = 1'b1;
                    plru_way   = fill_way;
                    next_state = icache_pkg::compare_s;
                end
            end
            icache_pkg::prefetch_s: begin
                // Neighbour already cached, nothing to fetch
                if (hit) begin
                    next_state = icache_pkg::idle_s;
                end else begin
                    mem_read = 1'b1;
                    if (mem_resp) begin
                        arr.wr_en  = 1'b1;
                        plru_touch = 1'b1;
                        plru_way   = fill_way;
                        next_state = icache_pkg::idle_s;
                    end
                end
            end
            default: begin
                next_state = icache_pkg::idle_s;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q <= icache_pkg::idle_s;
            fill_q  <= 1'b0;
        end else begin
            state_q <= next_state;
            if (state_q == icache_pkg::allocate_s && mem_resp) begin
                fill_q <= 1'b1;
            end else if (state_q == icache_pkg::prefetch_s) begin
                fill_q <= 1'b0;
            end
        end
    end

    // Request address captured when taken in idle
    always_ff @(posedge clk) begin
        if (state_q == icache_pkg::idle_s && cpu_read) begin
            req_q <= cpu_addr;
        end
    end

endmodule

// File: verilog/icache_plru.sv
`timescale 1ns/1ps

module icache_plru (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic [icache_pkg::index_w-1:0] index,
    input  logic                           touch,
    input  logic [icache_pkg::way_w-1:0]   touch_way,
    output logic [icache_pkg::way_w-1:0]   victim_way
);

    // Bit 0 picks the pair, bit 1 picks within ways 0-1, bit 2 within ways 2-3.
    // A set bit points the victim at the upper way or pair.
    logic [icache_pkg::sets-1:0][2:0] tree_q;
    logic [2:0]                       tree_cur;

    assign tree_cur = tree_q[index];

    // Point the tree away from the way just used
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tree_q <= '0;
        end else if (touch) begin
            tree_q[index][0] <= ~touch_way[1];
            if (touch_way[1]) begin
                tree_q[index][2] <= ~touch_way[0];
            end else begin
                tree_q[index][1] <= ~touch_way[0];
            end
        end
    end

    // Walk the tree for the current set
    always_comb begin
        if (tree_cur[0]) begin
            victim_way = {1'b1, tree_cur[2]};
        end else begin
            victim_way = {1'b0, tree_cur[1]};
        end
    end

endmodule

// File: verilog/icache_ways.sv
`timescale 1ns/1ps

module icache_ways (
    input logic           clk,
    input logic           arst_n,
    icache_array_if.store arr
);

    logic [icache_pkg::ways-1:0][icache_pkg::sets-1:0] valid_q;

    logic [icache_pkg::tag_w-1:0]  tag_mem  [icache_pkg::ways][icache_pkg::sets];
    logic [icache_pkg::line_w-1:0] line_mem [icache_pkg::ways][icache_pkg::sets];

    // Valid bits start cleared so every set is cold after reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (arr.wr_en) begin
            valid_q[arr.wr_way][arr.index] <= 1'b1;
        end
    end

    // Tag and data storage
    always_ff @(posedge clk) begin
        if (arr.wr_en) begin
            tag_mem[arr.wr_way][arr.index]  <= arr.wr_tag;
            line_mem[arr.wr_way][arr.index] <= arr.wr_line;
        end
    end

    // All four ways of the indexed set, read without a clock
    always_comb begin
        for (int w = 0; w < icache_pkg::ways; w++) begin
            arr.rd_valid[w] = valid_q[w][arr.index];
            arr.rd_tag[w]   = tag_mem[w][arr.index];
            arr.rd_line[w]  = line_mem[w][arr.index];
        end
    end

endmodule

// File: verilog/icache_array_if.sv
`timescale 1ns/1ps

interface icache_array_if;

    // Set being looked up or written
    logic [icache_pkg::index_w-1:0] index;

    // Line install
    logic                          wr_en;
    logic [icache_pkg::way_w-1:0]  wr_way;
    logic [icache_pkg::tag_w-1:0]  wr_tag;
    logic [icache_pkg::line_w-1:0] wr_line;

    // All ways of the selected set
    logic [icache_pkg::ways-1:0]                          rd_valid;
    logic [icache_pkg::ways-1:0][icache_pkg::tag_w-1:0]   rd_tag;
    logic [icache_pkg::ways-1:0][icache_pkg::line_w-1:0]  rd_line;

    modport ctrl (
        output index,
        output wr_en,
        output wr_way,
        output wr_tag,
        output wr_line,
        input  rd_valid,
        input  rd_tag,
        input  rd_line
    );

    modport store (
        input  index,
        input  wr_en,
        input  wr_way,
        input  wr_tag,
        input  wr_line,
        output rd_valid,
        output rd_tag,
        output rd_line
    );

endinterface

// File: verilog/icache_pkg.sv
package icache_pkg;

    // Cache geometry
    localparam int ways     = 4;
    localparam int sets     = 16;
    localparam int index_w  = 4;
    localparam int offset_w = 5;
    localparam int tag_w    = 23;
    localparam int line_w   = 256;
    localparam int word_w   = 32;
    localparam int way_w    = 2;

    // Controller states
    typedef enum logic [1:0] {
        idle_s,
        compare_s,
        allocate_s,
        prefetch_s
    } ctrl_state_e;

    // Fetch address, seen either as a plain word or split into its fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] offset;
        } f;
    } addr_u;

endpackage
